//--- logic/booth_mult_consts.svh
`ifndef BOOTH_MULT_CONSTS_SVH
`define BOOTH_MULT_CONSTS_SVH

// Operand and result widths
`define OPERAND_W 8
`define PRODUCT_W 16

// Radix-8 digits needed for an unsigned 8-bit multiplier
`define GROUP_CNT 3

// Up to four times the multiplicand
`define TRIPLE_W 10

// Selected magnitude plus the sign-extension bit
`define PP_ROW_W 11

// Final adder covers product bits 15 down to 2
`define ADDER_W 14

// Sign-extension constant for rows 0 and 1 (-(2^10 + 2^13) mod 2^16)
`define CORR_BASE 16'hdc00

`endif

//--- logic/booth_mult_pkg.sv
`include "booth_mult_consts.svh"

package booth_mult_pkg;

   // Operands and result
   typedef logic [`OPERAND_W-1:0] operand_t;
   typedef logic [`PRODUCT_W-1:0] product_t;

   // Three times the multiplicand
   typedef logic [`TRIPLE_W-1:0] triple_t;

   // One flag per Booth digit
   typedef logic [`GROUP_CNT-1:0] digit_flags_t;

   // Partial-product row with its top sign-extension bit
   typedef logic [`PP_ROW_W-1:0] pp_row_t;

   // Wallace carry row, bit 0 weighs 2^2
   typedef logic [`PRODUCT_W-3:0] carry_row_t;

   // Final adder operand and sum
   typedef logic [`ADDER_W-1:0] adder_word_t;

endpackage

//--- logic/booth_encoder.sv
`timescale 1ns/10ps
`include "booth_mult_consts.svh"

module booth_encoder (
   input  booth_mult_pkg::operand_t     b,
   output booth_mult_pkg::digit_flags_t single,
   output booth_mult_pkg::digit_flags_t double,
   output booth_mult_pkg::digit_flags_t triple,
   output booth_mult_pkg::digit_flags_t quad,
   output booth_mult_pkg::digit_flags_t neg
);

   logic [3:0] win [`GROUP_CNT];

   // Overlapping windows, one shared bit between neighbors
   assign win[0] = {b[2:0], 1'b0};
   assign win[1] = b[5:2];
   // Zero on top, so the last digit is never negative
   assign win[2] = {1'b0, b[7:5]};

   for (genvar j = 0; j < `GROUP_CNT; j++) begin : g_digit
      logic x01;
      logic x12;
      logic x23;

      assign x01 = win[j][0] ^ win[j][1];
      assign x12 = win[j][1] ^ win[j][2];
      assign x23 = win[j][2] ^ win[j][3];

      // One-hot magnitude, all zero for a digit of 0
      assign single[j] = x01 & ~x23;
      assign double[j] = x12 & ~x01;
      assign triple[j] = x01 & x23;
      assign quad[j]   = x23 & ~x01 & ~x12;

      assign neg[j] = win[j][3];
   end

endmodule

//--- logic/partial_product_gen.sv
`timescale 1ns/10ps
`include "booth_mult_consts.svh"

module partial_product_gen (
   input  booth_mult_pkg::operand_t     a,
   input  booth_mult_pkg::digit_flags_t single,
   input  booth_mult_pkg::digit_flags_t double,
   input  booth_mult_pkg::digit_flags_t triple,
   input  booth_mult_pkg::digit_flags_t quad,
   input  booth_mult_pkg::digit_flags_t neg,
   output booth_mult_pkg::pp_row_t      row0,
   output booth_mult_pkg::pp_row_t      row1,
   output booth_mult_pkg::pp_row_t      row2,
   output booth_mult_pkg::product_t     correction
);

   booth_mult_pkg::triple_t a3;
   logic [`OPERAND_W+3:0]   a_pad;
   logic [`TRIPLE_W-1:0]    mag [`GROUP_CNT];

   // 3a = a + 2a
   assign a3 = {2'b00, a} + {1'b0, a, 1'b0};

   // Two zeros each side so 1a, 2a and 4a are plain index offsets
   assign a_pad = {2'b00, a, 2'b00};

   for (genvar j = 0; j < `GROUP_CNT; j++) begin : g_row
      for (genvar k = 0; k < `TRIPLE_W; k++) begin : g_bit
         logic pick;

         assign pick = (single[j] & a_pad[k+2]) |
                       (double[j] & a_pad[k+1]) |
                       (quad[j]   & a_pad[k])   |
                       (triple[j] & a3[k]);

         // Ones' complement for negative digits
         assign mag[j][k] = pick ^ neg[j];
      end
   end

   // Inverted sign on top, the rest of the extension sits in the correction
   assign row0 = {~neg[0], mag[0]};
   assign row1 = {~neg[1], mag[1]};

   // Top digit is never negative, no sign bit needed
   assign row2 = {1'b0, mag[2]};

   // +1 of the two's complement lands at each row's offset (bits 0 and 3)
   assign correction = `CORR_BASE | {12'h000, neg[1], 2'b00, neg[0]};

endmodule

//--- logic/wallace_tree.sv
`timescale 1ns/10ps
`include "booth_mult_consts.svh"

module wallace_tree (
   input  booth_mult_pkg::pp_row_t    row0,
   input  booth_mult_pkg::pp_row_t    row1,
   input  booth_mult_pkg::pp_row_t    row2,
   input  booth_mult_pkg::product_t   correction,
   output booth_mult_pkg::product_t   sum_row,
   output booth_mult_pkg::carry_row_t carry_row
);

   // Stage one sum at weight p, carry at weight p+1
   booth_mult_pkg::product_t s1_sum;
   logic [`PRODUCT_W-2:0]    s1_carry;

   // Returns {carry, sum}
   function automatic logic [1:0] half_add(input logic x, input logic y);
      return {x & y, x ^ y};
   endfunction

   function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
      logic t;
      t = x ^ y;
      return {(t & z) | (x & y), t ^ z};
   endfunction

   // Rows sit at offsets 0, 3 and 6
   for (genvar p = 0; p < `PRODUCT_W; p++) begin : g_stage1
      if (p < 3) begin : g_ha_low
         assign {s1_carry[p], s1_sum[p]} = half_add(correction[p], row0[p]);
      end else if (p < `PP_ROW_W) begin : g_fa_r01
         assign {s1_carry[p], s1_sum[p]} = full_add(correction[p], row0[p], row1[p-3]);
      end else if (p < 14) begin : g_fa_r12
         assign {s1_carry[p], s1_sum[p]} = full_add(correction[p], row1[p-3], row2[p-6]);
      end else begin : g_ha_high
         if (p < `PRODUCT_W-1) begin : g_cout
            assign {s1_carry[p], s1_sum[p]} = half_add(correction[p], row2[p-6]);
         end else begin : g_msb
            // Carry out of bit 15 falls off the product
            assign s1_sum[p] = correction[p] ^ row2[p-6];
         end
      end
   end

   // Low row2 bits 0..4 skipped stage one and join here at weights 6..10
   assign sum_row[0] = s1_sum[0];

   for (genvar p = 1; p < `PRODUCT_W; p++) begin : g_stage2
      if (p >= 6 && p <= 10) begin : g_fa
         assign {carry_row[p-1], sum_row[p]} = full_add(s1_sum[p], s1_carry[p-1], row2[p-6]);
      end else if (p < `PRODUCT_W-1) begin : g_ha
         assign {carry_row[p-1], sum_row[p]} = half_add(s1_sum[p], s1_carry[p-1]);
      end else begin : g_msb
         assign sum_row[p] = s1_sum[p] ^ s1_carry[p-1];
      end
   end

endmodule

//--- logic/prefix_adder.sv
`timescale 1ns/10ps
`include "booth_mult_consts.svh"

module prefix_adder (
   input  booth_mult_pkg::adder_word_t opa,
   input  booth_mult_pkg::adder_word_t opb,
   output booth_mult_pkg::adder_word_t sum
);

   // Index n holds the group ending just below bit n, index 0 is the carry-in
   booth_mult_pkg::adder_word_t gen_lvl [5];
   booth_mult_pkg::adder_word_t prop_lvl [4];

   // Carry-in is zero and never propagates
   assign gen_lvl[0][0]  = 1'b0;
   assign prop_lvl[0][0] = 1'b0;

   for (genvar n = 1; n < `ADDER_W; n++) begin : g_pre
      assign gen_lvl[0][n]  = opa[n-1] & opb[n-1];
      assign prop_lvl[0][n] = opa[n-1] | opb[n-1];
   end

   // Spans 1, 2, 4, 8
   for (genvar lvl = 0; lvl < 4; lvl++) begin : g_level
      for (genvar n = 0; n < `ADDER_W; n++) begin : g_node
         if (n < (1 << lvl)) begin : g_pass
            // Group already reaches the carry-in
            assign gen_lvl[lvl+1][n] = gen_lvl[lvl][n];
            if (lvl < 3) begin : g_prop
               assign prop_lvl[lvl+1][n] = prop_lvl[lvl][n];
            end
         end else begin : g_merge
            assign gen_lvl[lvl+1][n] = gen_lvl[lvl][n] |
                                       (prop_lvl[lvl][n] & gen_lvl[lvl][n-(1<<lvl)]);
            if (lvl < 3) begin : g_prop
               assign prop_lvl[lvl+1][n] = prop_lvl[lvl][n] & prop_lvl[lvl][n-(1<<lvl)];
            end
         end
      end
   end

   // Carry into each bit is the last level's generate
   assign sum = opa ^ opb ^ gen_lvl[4];

endmodule

//--- logic/booth_mult.sv
`timescale 1ns/10ps
`include "booth_mult_consts.svh"

module booth_mult (
   input  logic                     clk,
   input  logic                     rst,
   input  booth_mult_pkg::operand_t a,
   input  booth_mult_pkg::operand_t b,
   output booth_mult_pkg::product_t product
);

   booth_mult_pkg::digit_flags_t single;
   booth_mult_pkg::digit_flags_t double;
   booth_mult_pkg::digit_flags_t triple;
   booth_mult_pkg::digit_flags_t quad;
   booth_mult_pkg::digit_flags_t neg;
   booth_mult_pkg::pp_row_t      row0;
   booth_mult_pkg::pp_row_t      row1;
   booth_mult_pkg::pp_row_t      row2;
   booth_mult_pkg::product_t     correction;
   booth_mult_pkg::product_t     sum_row;
   booth_mult_pkg::carry_row_t   carry_row;
   booth_mult_pkg::adder_word_t  upper_sum;

   booth_encoder u_encoder (
      .b      (b),
      .single (single),
      .double (double),
      .triple (triple),
      .quad   (quad),
      .neg    (neg)
   );

   partial_product_gen u_ppgen (
      .a          (a),
      .single     (single),
      .double     (double),
      .triple     (triple),
      .quad       (quad),
      .neg        (neg),
      .row0       (row0),
      .row1       (row1),
      .row2       (row2),
      .correction (correction)
   );

   wallace_tree u_tree (
      .row0       (row0),
      .row1       (row1),
      .row2       (row2),
      .correction (correction),
      .sum_row    (sum_row),
      .carry_row  (carry_row)
   );

   // Carry row starts at weight 2, so bits 1:0 are already final
   prefix_adder u_adder (
      .opa (sum_row[`PRODUCT_W-1:2]),
      .opb (carry_row),
      .sum (upper_sum)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         product <= '0;
      end else begin
         product <= {upper_sum, sum_row[1:0]};
      end
   end

endmodule

//--- test/tb_booth_mult.sv
`timescale 1ns/10ps

module tb_booth_mult;

   localparam int TBL_LEN = 20;
   localparam int RAND_CNT = 200;
   localparam int WATCHDOG_NS = (TBL_LEN + RAND_CNT + 10) * 10;

   logic                     clk;
   logic                     rst;
   booth_mult_pkg::operand_t a;
   booth_mult_pkg::operand_t b;
   booth_mult_pkg::product_t product;

   // Each entry is {a, b, expected product}
   logic [31:0] vec_table [TBL_LEN] = '{
      {8'd0,   8'd0,   16'd0},
      {8'd37,  8'd1,   16'd37},
      {8'd37,  8'd2,   16'd74},
      {8'd37,  8'd3,   16'd111},
      {8'd37,  8'd4,   16'd148},
      {8'd91,  8'd16,  16'd1456},
      {8'd91,  8'd24,  16'd2184},
      {8'd91,  8'd64,  16'd5824},
      {8'd0,   8'd7,   16'd0},
      {8'd1,   8'd63,  16'd63},
      {8'd128, 8'd200, 16'd25600},
      {8'd255, 8'd255, 16'd65025},
      {8'd255, 8'd7,   16'd1785},
      {8'd128, 8'd63,  16'd8064},
      {8'd1,   8'd200, 16'd200},
      {8'd255, 8'd129, 16'd32895},
      {8'd170, 8'd85,  16'd14450},
      {8'd255, 8'd200, 16'd51000},
      {8'd200, 8'd255, 16'd51000},
      {8'd129, 8'd255, 16'd32895}
   };

   int errors;
   int checks;

   // Pair in flight until the next edge checks it
   logic                     have_pending;
   booth_mult_pkg::operand_t pending_a;
   booth_mult_pkg::operand_t pending_b;
   booth_mult_pkg::product_t pending_exp;

   booth_mult uut (
      .clk     (clk),
      .rst     (rst),
      .a       (a),
      .b       (b),
      .product (product)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_product(input booth_mult_pkg::product_t got,
                                input booth_mult_pkg::product_t exp,
                                input booth_mult_pkg::operand_t x,
                                input booth_mult_pkg::operand_t y);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %0d * %0d gave %0d, expected %0d",
                  $time, x, y, got, exp);
      end
   endtask

   task automatic check_reset(input booth_mult_pkg::product_t got);
      checks++;
      if (got !== '0) begin
         errors++;
         $display("mismatch at %0t: product is %0h after reset, expected 0", $time, got);
      end
   endtask

   task automatic drive_pair(input booth_mult_pkg::operand_t na,
                             input booth_mult_pkg::operand_t nb,
                             input booth_mult_pkg::product_t nexp);
      a = na;
      b = nb;
      pending_a = na;
      pending_b = nb;
      pending_exp = nexp;
      have_pending = 1'b1;
   endtask

   // Advance to just after the next rising edge and check what was in flight
   task automatic next_cycle();
      @(posedge clk);
      #1;
      if (have_pending) begin
         check_product(product, pending_exp, pending_a, pending_b);
      end
      have_pending = 1'b0;
   endtask

   initial begin
      booth_mult_pkg::operand_t ra;
      booth_mult_pkg::operand_t rb;
      errors = 0;
      checks = 0;
      have_pending = 1'b0;
      pending_a = '0;
      pending_b = '0;
      pending_exp = '0;
      rst = 1'b1;
      // Nonzero operands expose a product that ignores reset
      a = 8'd255;
      b = 8'd255;
      void'($urandom(73));

      repeat (2) @(posedge clk);
      #1;
      check_reset(product);
      rst = 1'b0;

      for (int i = 0; i < TBL_LEN; i++) begin
         drive_pair(vec_table[i][31:24], vec_table[i][23:16], vec_table[i][15:0]);
         next_cycle();
      end

      // Reset pulse with a live operand pair on the inputs
      rst = 1'b1;
      a = 8'd255;
      b = 8'd255;
      next_cycle();
      check_reset(product);
      rst = 1'b0;
      drive_pair(8'd170, 8'd85, 16'd14450);
      next_cycle();

      // Back-to-back random pairs
      for (int i = 0; i < RAND_CNT; i++) begin
         ra = booth_mult_pkg::operand_t'($urandom % 256);
         rb = booth_mult_pkg::operand_t'($urandom % 256);
         drive_pair(ra, rb, booth_mult_pkg::product_t'(int'(ra) * int'(rb)));
         next_cycle();
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- sources.f
+incdir+logic
logic/booth_mult_pkg.sv
logic/booth_encoder.sv
logic/partial_product_gen.sv
logic/wallace_tree.sv
logic/prefix_adder.sv
logic/booth_mult.sv
test/tb_booth_mult.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the booth_mult testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/10ps -f sources.f \
   --top-module tb_booth_mult -o sim_booth_mult

./obj_dir/sim_booth_mult > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
   echo "Testbench reported failure"
   exit 1
fi

echo "Testbench reported no failure"
exit 0
